//--- compile.f
+incdir+testbench
common/sampler_pkg.sv
verilog/slot_switch_decoder.sv
verilog/pad_decoder.sv
sampler_control/mode_controller.sv
verilog/sampler_top.sv
testbench/tb_sampler_top.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the sampler testbench with Verilator and runs it.
# The exit status is the simulator's status.

set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
    --top-module tb_sampler_top \
    -f compile.f \
    -Mdir obj_dir \
    -o sim_sampler
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

./obj_dir/sim_sampler
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished cleanly"
exit 0

//--- testbench/tb_sampler_model.svh
`ifndef TB_SAMPLER_MODEL_SVH
`define TB_SAMPLER_MODEL_SVH

// model state of the controller registers
logic [1:0]  model_mode;
logic        model_page;
logic        model_armed;
logic [22:0] model_addr;

// expected outputs for the cycle under test
logic [1:0]  exp_mode;
logic        exp_page;
logic        exp_rec_start;
logic        exp_rec_stop;
logic [22:0] exp_rec_select;
logic        exp_play_start;
logic        exp_play_stop;
logic [22:0] exp_play_select;
logic [22:0] exp_play_overlay;
logic        exp_play_record;
logic [1:0]  exp_play_speed;
logic        exp_mix_start;
logic        exp_mix_stop;
logic [16:0] exp_mix_num;
logic [22:0] exp_mix_overlay;
logic [15:0] exp_mix_loop;

// 32-bit xorshift step
function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// chunk base holds the slot index in bits 22..19
function automatic logic [22:0] base_of(input logic [3:0] slot);
    return {slot, 19'd0};
endfunction

// index of the single set bit or -1 for none or several
function automatic int hot_index(input logic [15:0] v);
    int idx;
    int count;
    idx = -1;
    count = 0;
    for (int i = 0; i < 16; i++) begin
        if (v[i]) begin
            count++;
            idx = i;
        end
    end
    if (count != 1) begin
        idx = -1;
    end
    return idx;
endfunction

task automatic reset_model();
    model_mode = sampler_pkg::mode_idle;
    model_page = 1'b0;
    model_armed = 1'b0;
    model_addr = '0;
endtask

// one clock edge using the inputs seen before the edge
task automatic advance_model();
    int sidx;
    sidx = hot_index(sw[15:0]);
    case (model_mode)
        sampler_pkg::mode_idle: begin
            // mix over play over record
            if (gpio[sampler_pkg::gpio_mix]) begin
                model_mode = sampler_pkg::mode_mix;
            end else if (gpio[sampler_pkg::gpio_play]) begin
                model_mode = sampler_pkg::mode_play;
            end else if (gpio[sampler_pkg::gpio_rec]) begin
                model_mode = sampler_pkg::mode_rec;
            end
            if (sidx >= 0) begin
                model_armed = 1'b1;
                model_addr = base_of(sidx[3:0]);
            end else begin
                model_armed = 1'b0;
                model_addr = 23'd1;
            end
        end
        sampler_pkg::mode_rec: begin
            if (record_done) begin
                model_mode = sampler_pkg::mode_idle;
            end
        end
        default: begin
            // play and mix share the done and page rules
            if ((model_mode == sampler_pkg::mode_play && play_done) ||
                (model_mode == sampler_pkg::mode_mix && mix_done)) begin
                model_mode = sampler_pkg::mode_idle;
            end
            if (gpio[sampler_pkg::gpio_rec]) begin
                model_page = !model_page;
            end
        end
    endcase
endtask

`endif

//--- testbench/tb_sampler_top.sv
`timescale 1ns/1ps

module tb_sampler_top;

    localparam int reset_cycles = 5;
    localparam int run_cycles = 4000;
    // reset and random run with a wide margin
    localparam int cycle_limit = run_cycles + 1000;

    logic        i_clk;
    logic        i_rst;
    logic [17:0] sw;
    logic [13:0] gpio;
    logic        record_done;
    logic        play_done;
    logic        mix_done;
    logic [1:0]  mode;
    logic        hex_page;
    logic        record_start;
    logic        record_stop;
    logic [22:0] record_select;
    logic        play_start;
    logic        play_stop;
    logic [22:0] play_select;
    logic [22:0] play_overlay_select;
    logic        play_record;
    logic [1:0]  play_speed;
    logic        mix_start;
    logic        mix_stop;
    logic [16:0] mix_num;
    logic [22:0] mix_overlay_select;
    logic [15:0] mix_loop;

    logic [31:0] rng_state;
    int          cycle_count = 0;
    string       test_name;

    `include "tb_sampler_model.svh"

    sampler_top dut (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .sw                  (sw),
        .gpio                (gpio),
        .record_done         (record_done),
        .play_done           (play_done),
        .mix_done            (mix_done),
        .mode                (mode),
        .hex_page            (hex_page),
        .record_start        (record_start),
        .record_stop         (record_stop),
        .record_select       (record_select),
        .play_start          (play_start),
        .play_stop           (play_stop),
        .play_select         (play_select),
        .play_overlay_select (play_overlay_select),
        .play_record         (play_record),
        .play_speed          (play_speed),
        .mix_start           (mix_start),
        .mix_stop            (mix_stop),
        .mix_num             (mix_num),
        .mix_overlay_select  (mix_overlay_select),
        .mix_loop            (mix_loop)
    );

    always #5 i_clk = ~i_clk;

    // run length guard
    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= cycle_limit) begin
            $display("Timeout: the run did not end within %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped by the cycle limit");
        end
    end

    // expected values derived from the current model state and the present inputs
    task automatic predict_outputs();
        int sidx;
        int pidx;
        logic [3:0] slot;
        logic blocked;
        sidx = hot_index(sw[15:0]);
        pidx = hot_index({8'd0, gpio[sampler_pkg::gpio_pad_hi], gpio[6:0]});
        slot = {model_page, pidx[2:0]};
        blocked = model_armed && (model_addr == base_of(slot));
        exp_mode = model_mode;
        exp_page = model_page;
        exp_rec_start = 1'b0;
        exp_rec_stop = 1'b0;
        exp_rec_select = '0;
        exp_play_start = 1'b0;
        exp_play_stop = 1'b0;
        exp_play_select = '0;
        exp_play_overlay = '0;
        exp_play_record = 1'b0;
        exp_play_speed = '0;
        exp_mix_start = 1'b0;
        exp_mix_stop = 1'b0;
        exp_mix_num = '0;
        exp_mix_overlay = '0;
        exp_mix_loop = '0;
        case (model_mode)
            sampler_pkg::mode_rec: begin
                exp_rec_start = (sidx >= 0);
                exp_rec_select = (sidx >= 0) ? base_of(sidx[3:0]) : 23'h020000;
                exp_rec_stop = gpio[sampler_pkg::gpio_stop];
            end
            sampler_pkg::mode_play: begin
                if (pidx >= 0) begin
                    exp_play_select = base_of(slot);
                    exp_play_start = !blocked;
                end
                exp_play_record = model_armed;
                exp_play_overlay = model_armed ? model_addr : 23'd0;
                exp_play_speed = sw[16:15];
                exp_play_stop = gpio[sampler_pkg::gpio_stop];
            end
            sampler_pkg::mode_mix: begin
                exp_mix_start = 1'b1;
                if (pidx >= 0 && !blocked) begin
                    exp_mix_num[slot] = 1'b1;
                end
                exp_mix_num[16] = model_armed;
                exp_mix_overlay = model_armed ? model_addr : 23'd0;
                exp_mix_loop = sw[15:0];
                exp_mix_stop = gpio[sampler_pkg::gpio_stop];
            end
            default: begin
            end
        endcase
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s test, %s at cycle %0d: expected %0h, actual %0h",
                     test_name, name, cycle_count, expected, actual);
            $display("SIMULATION FAILED");
            $fatal(1, "stopped at the first wrong output");
        end
    endtask

    task automatic compare_outputs();
        check_value("mode", 32'(exp_mode), 32'(mode));
        check_value("hex_page", 32'(exp_page), 32'(hex_page));
        check_value("record_start", 32'(exp_rec_start), 32'(record_start));
        check_value("record_stop", 32'(exp_rec_stop), 32'(record_stop));
        check_value("record_select", 32'(exp_rec_select), 32'(record_select));
        check_value("play_start", 32'(exp_play_start), 32'(play_start));
        check_value("play_stop", 32'(exp_play_stop), 32'(play_stop));
        check_value("play_select", 32'(exp_play_select), 32'(play_select));
        check_value("play_overlay_select", 32'(exp_play_overlay), 32'(play_overlay_select));
        check_value("play_record", 32'(exp_play_record), 32'(play_record));
        check_value("play_speed", 32'(exp_play_speed), 32'(play_speed));
        check_value("mix_start", 32'(exp_mix_start), 32'(mix_start));
        check_value("mix_stop", 32'(exp_mix_stop), 32'(mix_stop));
        check_value("mix_num", 32'(exp_mix_num), 32'(mix_num));
        check_value("mix_overlay_select", 32'(exp_mix_overlay), 32'(mix_overlay_select));
        check_value("mix_loop", 32'(exp_mix_loop), 32'(mix_loop));
    endtask

    // biased panel activity with mostly single switches and single pads
    task automatic drive_random();
        logic [31:0] r;
        logic [15:0] bank;
        logic [7:0] pad_vec;
        logic [13:0] g;
        rng_state = xorshift(rng_state);
        r = rng_state;
        bank = (r[3:0] < 4'd11) ? (16'd1 << r[7:4]) : r[31:16];
        sw <= {r[9:8], bank};
        rng_state = xorshift(rng_state);
        r = rng_state;
        pad_vec = (r[3:0] < 4'd12) ? (8'd1 << r[6:4]) : r[15:8];
        g = '0;
        g[6:0] = pad_vec[6:0];
        g[sampler_pkg::gpio_pad_hi] = pad_vec[7];
        // rare buttons with stop a bit more common
        g[sampler_pkg::gpio_rec] = (r[19:16] == 4'd0);
        g[sampler_pkg::gpio_play] = (r[23:20] == 4'd0);
        g[sampler_pkg::gpio_mix] = (r[27:24] == 4'd0);
        g[sampler_pkg::gpio_stop] = (r[29:28] == 2'd0);
        // unused header pins toggle freely
        g[7] = r[30];
        g[12] = r[31];
        rng_state = xorshift(rng_state);
        r = rng_state;
        record_done <= (r[4:0] == 5'd0);
        play_done <= (r[9:5] == 5'd0);
        mix_done <= (r[14:10] == 5'd0);
        // occasional chord of record and play and sometimes mix
        if (r[18:15] == 4'd0) begin
            g[sampler_pkg::gpio_rec] = 1'b1;
            g[sampler_pkg::gpio_play] = 1'b1;
            g[sampler_pkg::gpio_mix] = r[19];
        end
        gpio <= g;
    endtask

    initial begin
        i_clk = 1'b0;
        i_rst = 1'b1;
        sw = '0;
        gpio = '0;
        record_done = 1'b0;
        play_done = 1'b0;
        mix_done = 1'b0;
        rng_state = 32'd37635;
        test_name = "reset";
        reset_model();
        repeat (reset_cycles) @(posedge i_clk);
        i_rst <= 1'b0;
        // inputs still quiet so outputs show the reset state
        @(negedge i_clk);
        predict_outputs();
        compare_outputs();
        test_name = "random";
        for (int n = 0; n < run_cycles; n++) begin
            @(posedge i_clk);
            advance_model();
            drive_random();
            @(negedge i_clk);
            predict_outputs();
            compare_outputs();
        end
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

//--- verilog/sampler_top.sv
`timescale 1ns/1ps

module sampler_top (
    input  logic                           i_clk,
    input  logic                           i_rst,
    input  logic [17:0]                    sw,
    input  logic [13:0]                    gpio,
    input  logic                           record_done,
    input  logic                           play_done,
    input  logic                           mix_done,
    output logic [sampler_pkg::mode_w-1:0] mode,
    output logic                           hex_page,
    output logic                           record_start,
    output logic                           record_stop,
    output logic [sampler_pkg::addr_w-1:0] record_select,
    output logic                           play_start,
    output logic                           play_stop,
    output logic [sampler_pkg::addr_w-1:0] play_select,
    output logic [sampler_pkg::addr_w-1:0] play_overlay_select,
    output logic                           play_record,
    output logic [1:0]                     play_speed,
    output logic                           mix_start,
    output logic                           mix_stop,
    output logic [16:0]                    mix_num,
    output logic [sampler_pkg::addr_w-1:0] mix_overlay_select,
    output logic [15:0]                    mix_loop
);

    logic                          slot_valid;
    logic [sampler_pkg::slot_w-1:0] slot_idx;
    logic                          pad_valid;
    logic [sampler_pkg::pad_w-1:0]  pad_idx;
    // pad 7 comes from gpio 13, pads 0..6 from gpio 6..0
    logic [sampler_pkg::num_pads-1:0] pads;

    assign pads = {gpio[sampler_pkg::gpio_pad_hi], gpio[6:0]};

    // chunk switches sw[15:0]
    slot_switch_decoder u_slot_switch_decoder (
        .sw_bank    (sw[sampler_pkg::num_slots-1:0]),
        .slot_valid (slot_valid),
        .slot_idx   (slot_idx)
    );

    pad_decoder u_pad_decoder (
        .pads      (pads),
        .pad_valid (pad_valid),
        .pad_idx   (pad_idx)
    );

    // speed shares sw[15] with the top chunk switch
    mode_controller u_mode_controller (
        .i_clk               (i_clk),
        .i_rst               (i_rst),
        .rec_btn             (gpio[sampler_pkg::gpio_rec]),
        .play_btn            (gpio[sampler_pkg::gpio_play]),
        .mix_btn             (gpio[sampler_pkg::gpio_mix]),
        .stop_btn            (gpio[sampler_pkg::gpio_stop]),
        .slot_valid          (slot_valid),
        .slot_idx            (slot_idx),
        .pad_valid           (pad_valid),
        .pad_idx             (pad_idx),
        .speed_sw            (sw[16:15]),
        .loop_sw             (sw[15:0]),
        .record_done         (record_done),
        .play_done           (play_done),
        .mix_done            (mix_done),
        .mode                (mode),
        .hex_page            (hex_page),
        .record_start        (record_start),
        .record_stop         (record_stop),
        .record_select       (record_select),
        .play_start          (play_start),
        .play_stop           (play_stop),
        .play_select         (play_select),
        .play_overlay_select (play_overlay_select),
        .play_record         (play_record),
        .play_speed          (play_speed),
        .mix_start           (mix_start),
        .mix_stop            (mix_stop),
        .mix_num             (mix_num),
        .mix_overlay_select  (mix_overlay_select),
        .mix_loop            (mix_loop)
    );

endmodule

//--- sampler_control/mode_controller.sv
`timescale 1ns/1ps

module mode_controller (
    input  logic                              i_clk,
    input  logic                              i_rst,
    // panel buttons
    input  logic                              rec_btn,
    input  logic                              play_btn,
    input  logic                              mix_btn,
    input  logic                              stop_btn,
    // decoded switch bank
    input  logic                              slot_valid,
    input  logic [sampler_pkg::slot_w-1:0]    slot_idx,
    // decoded pads
    input  logic                              pad_valid,
    input  logic [sampler_pkg::pad_w-1:0]     pad_idx,
    // raw switch fields
    input  logic [1:0]                        speed_sw,
    input  logic [15:0]                       loop_sw,
    // engine completion
    input  logic                              record_done,
    input  logic                              play_done,
    input  logic                              mix_done,
    output logic [sampler_pkg::mode_w-1:0]    mode,
    output logic                              hex_page,
    // record engine
    output logic                              record_start,
    output logic                              record_stop,
    output logic [sampler_pkg::addr_w-1:0]    record_select,
    // play engine
    output logic                              play_start,
    output logic                              play_stop,
    output logic [sampler_pkg::addr_w-1:0]    play_select,
    output logic [sampler_pkg::addr_w-1:0]    play_overlay_select,
    output logic                              play_record,
    output logic [1:0]                        play_speed,
    // mix engine
    output logic                              mix_start,
    output logic                              mix_stop,
    output logic [16:0]                       mix_num,
    output logic [sampler_pkg::addr_w-1:0]    mix_overlay_select,
    output logic [15:0]                       mix_loop
);

    // slot index to chunk base address
    function automatic logic [sampler_pkg::addr_w-1:0] chunk_base(
        input logic [sampler_pkg::slot_w-1:0] slot
    );
        logic [sampler_pkg::addr_w-1:0] base;
        base = '0;
        base[sampler_pkg::chunk_shift +: sampler_pkg::slot_w] = slot;
        return base;
    endfunction

    logic [sampler_pkg::mode_w-1:0] mode_next;
    logic page;
    logic page_next;
    // overlay store, armed bit plus address
    logic store_armed;
    logic store_armed_next;
    logic [sampler_pkg::addr_w-1:0] store_addr;
    logic [sampler_pkg::addr_w-1:0] store_addr_next;

    // page bit picks upper or lower eight chunks
    logic [sampler_pkg::slot_w-1:0] active_slot;
    logic [sampler_pkg::addr_w-1:0] active_base;
    logic [sampler_pkg::addr_w-1:0] switch_base;
    // pad names the chunk already armed as overlay
    logic slot_blocked;

    assign active_slot = {page, pad_idx};
    assign active_base = chunk_base(active_slot);
    assign switch_base = chunk_base(slot_idx);
    assign slot_blocked = store_armed && (store_addr == active_base);

    assign hex_page = page;

    always_ff @(posedge i_clk or posedge i_rst) begin
        if (i_rst) begin
            mode <= sampler_pkg::mode_idle;
            page <= 1'b0;
            store_armed <= 1'b0;
            store_addr <= '0;
        end else begin
            mode <= mode_next;
            page <= page_next;
            store_armed <= store_armed_next;
            store_addr <= store_addr_next;
        end
    end

    always_comb begin
        // hold state, all strobes low
        mode_next = mode;
        page_next = page;
        store_armed_next = store_armed;
        store_addr_next = store_addr;
        record_start = 1'b0;
        record_stop = 1'b0;
        record_select = '0;
        play_start = 1'b0;
        play_stop = 1'b0;
        play_select = '0;
        play_overlay_select = '0;
        play_record = 1'b0;
        play_speed = 2'b00;
        mix_start = 1'b0;
        mix_stop = 1'b0;
        mix_num = '0;
        mix_overlay_select = '0;
        mix_loop = '0;

        case (mode)
            sampler_pkg::mode_idle: begin
                // mix wins over play, play over record
                if (mix_btn) begin
                    mode_next = sampler_pkg::mode_mix;
                end else if (play_btn) begin
                    mode_next = sampler_pkg::mode_play;
                end else if (rec_btn) begin
                    mode_next = sampler_pkg::mode_rec;
                end
                // overlay follows the switch bank while idle
                if (slot_valid) begin
                    store_armed_next = 1'b1;
                    store_addr_next = switch_base;
                end else begin
                    store_armed_next = 1'b0;
                    store_addr_next = sampler_pkg::store_idle_addr;
                end
            end

            sampler_pkg::mode_rec: begin
                if (slot_valid) begin
                    record_select = switch_base;
                    record_start = 1'b1;
                end else begin
                    // no chunk picked, park on the default target
                    record_select = sampler_pkg::rec_default_addr;
                end
                record_stop = stop_btn;
                if (record_done) begin
                    mode_next = sampler_pkg::mode_idle;
                end
            end

            sampler_pkg::mode_play: begin
                if (pad_valid) begin
                    play_select = active_base;
                    // overlay chunk is not replayed as the main track
                    play_start = !slot_blocked;
                end
                // armed overlay records alongside playback
                if (store_armed) begin
                    play_overlay_select = store_addr;
                    play_record = 1'b1;
                end
                play_speed = speed_sw;
                play_stop = stop_btn;
                if (play_done) begin
                    mode_next = sampler_pkg::mode_idle;
                end
                // record button doubles as page flip
                if (rec_btn) begin
                    page_next = !page;
                end
            end

            sampler_pkg::mode_mix: begin
                mix_start = 1'b1;
                // one mask bit per chunk
                if (pad_valid && !slot_blocked) begin
                    mix_num[active_slot] = 1'b1;
                end
                // bit 16 flags the overlay track
                if (store_armed) begin
                    mix_num[16] = 1'b1;
                    mix_overlay_select = store_addr;
                end
                mix_loop = loop_sw;
                mix_stop = stop_btn;
                if (mix_done) begin
                    mode_next = sampler_pkg::mode_idle;
                end
                if (rec_btn) begin
                    page_next = !page;
                end
            end
        endcase
    end

endmodule

//--- verilog/pad_decoder.sv
`timescale 1ns/1ps

module pad_decoder (
    input  logic [sampler_pkg::num_pads-1:0] pads,
    output logic                             pad_valid,
    output logic [sampler_pkg::pad_w-1:0]    pad_idx
);

    // one-hot pad patterns, anything else is a chord or nothing
    always_comb begin
        pad_valid = 1'b1;
        pad_idx = '0;
        case (pads)
            8'b0000_0001: begin
                pad_idx = 3'd0;
            end
            8'b0000_0010: begin
                pad_idx = 3'd1;
            end
            8'b0000_0100: begin
                pad_idx = 3'd2;
            end
            8'b0000_1000: begin
                pad_idx = 3'd3;
            end
            8'b0001_0000: begin
                pad_idx = 3'd4;
            end
            8'b0010_0000: begin
                pad_idx = 3'd5;
            end
            8'b0100_0000: begin
                pad_idx = 3'd6;
            end
            8'b1000_0000: begin
                // the pad wired from gpio 13
                pad_idx = 3'd7;
            end
            default: begin
                // no pad or several at once
                pad_valid = 1'b0;
            end
        endcase
    end

endmodule

//--- verilog/slot_switch_decoder.sv
`timescale 1ns/1ps

module slot_switch_decoder (
    input  logic [sampler_pkg::num_slots-1:0] sw_bank,
    output logic                              slot_valid,
    output logic [sampler_pkg::slot_w-1:0]    slot_idx
);

    // at least one switch up
    logic seen;
    // a second switch found
    logic multi;
    // position of the last switch found
    logic [sampler_pkg::slot_w-1:0] idx;

    // scan the bank, flag anything that is not one-hot
    always_comb begin
        seen = 1'b0;
        multi = 1'b0;
        idx = '0;
        for (int i = 0; i < sampler_pkg::num_slots; i++) begin
            if (sw_bank[i]) begin
                if (seen) begin
                    multi = 1'b1;
                end
                seen = 1'b1;
                idx = i[sampler_pkg::slot_w-1:0];
            end
        end
    end

    // exactly one switch
    assign slot_valid = seen && !multi;

    // index forced to zero when invalid
    assign slot_idx = slot_valid ? idx : '0;

endmodule

//--- common/sampler_pkg.sv
package sampler_pkg;

    // memory layout: sixteen equal chunks
    localparam logic [4:0] num_slots = 5'd16;
    // slot index width
    localparam int slot_w = 4;

    // pads per page, two pages cover all chunks
    localparam logic [3:0] num_pads = 4'd8;
    localparam int pad_w = 3;

    // chunk address width seen by the audio engines
    localparam int addr_w = 23;

    // slot index sits at the top of the address, bits 22..19
    localparam logic [4:0] chunk_shift = 5'd19;

    // record target when the switch bank is not one-hot
    localparam logic [22:0] rec_default_addr = 23'h020000;

    // unarmed overlay marker
    // odd value, so never a chunk base
    localparam logic [22:0] store_idle_addr = 23'd1;

    // mode machine encodings
    localparam int mode_w = 2;
    localparam logic [1:0] mode_idle = 2'd0;
    localparam logic [1:0] mode_rec = 2'd1;
    localparam logic [1:0] mode_play = 2'd2;
    localparam logic [1:0] mode_mix = 2'd3;

    // panel buttons on the gpio header
    localparam logic [3:0] gpio_rec = 4'd11;
    localparam logic [3:0] gpio_play = 4'd10;
    localparam logic [3:0] gpio_mix = 4'd9;
    localparam logic [3:0] gpio_stop = 4'd8;

    // eighth pad lives apart from the rest
    // pads 0..6 are gpio 0..6
    localparam logic [3:0] gpio_pad_hi = 4'd13;

endpackage
